// File: src.f
source/gic_pkg.sv
source/gic_glb_if.sv
source/gic_word_if.sv
source/gic_cfg_reg.sv
source/gic_sipo.sv
source/gic_piso.sv
source/gic_core.sv
source/glb_sram.sv
source/gic_top.sv
testbench/tb_gic_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the global input controller testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
    --top-module tb_gic_top \
    --Mdir obj_dir \
    -o tb_gic_top \
    -f src.f

./obj_dir/tb_gic_top | tee "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

// File: testbench/tb_gic_top.sv
/*
 * Global input controller testbench
 * Random instructions in both directions with inbound gaps and
 * outbound stalls, checked against a model of the global buffer
 */
`timescale 1ns/1ps

module tb_gic_top
    import gic_pkg::*;
();

    localparam int NUM_INSTR      = 24;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (20 * 4 + 20);
    localparam int BASE_LIMIT     = 240;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      cfg_vld;
    logic      cfg_rdy;
    cfg_info_t cfg_info;
    logic      itf_cmd_vld;
    port_dat_t itf_out_dat;
    logic      itf_out_vld;
    logic      itf_out_last;
    logic      itf_out_rdy;
    port_dat_t itf_in_dat;
    logic      itf_in_vld;
    logic      itf_in_last;
    logic      itf_in_rdy;

    integer    seed;
    int        cycles;
    int        cmd_errors;
    int        beat_errors;
    int        last_errors;
    int        flag_errors;
    int        proto_errors;

    // Buffer model holding only the written words
    sram_dat_t model [int];
    int        last_wr_base;
    int        last_wr_cnt;

    gic_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld      (cfg_vld),
        .cfg_rdy      (cfg_rdy),
        .cfg_info     (cfg_info),
        .itf_cmd_vld  (itf_cmd_vld),
        .itf_out_dat  (itf_out_dat),
        .itf_out_vld  (itf_out_vld),
        .itf_out_last (itf_out_last),
        .itf_out_rdy  (itf_out_rdy),
        .itf_in_dat   (itf_in_dat),
        .itf_in_vld   (itf_in_vld),
        .itf_in_last  (itf_in_last),
        .itf_in_rdy   (itf_in_rdy)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_cmd(input port_dat_t got, input port_dat_t expected);
        if (got !== expected) begin
            cmd_errors++;
            $display("** Error at time %0t: itf_out_dat = %h, expected %h (command beat)",
                     $time, got, expected);
        end
    endtask

    task automatic check_beat(input port_dat_t got, input port_dat_t expected);
        if (got !== expected) begin
            beat_errors++;
            $display("** Error at time %0t: itf_out_dat = %h, expected %h",
                     $time, got, expected);
        end
    endtask

    task automatic check_last(input logic got, input logic expected);
        if (got !== expected) begin
            last_errors++;
            $display("** Error at time %0t: itf_out_last = %b, expected %b",
                     $time, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            flag_errors++;
            $display("** Error at time %0t: %s = %b, expected %b", $time, name, got, expected);
        end
    endtask

    // ========================================================================
    // Instruction choice
    // ========================================================================
    // Reads go back into the latest written region, writes land anywhere
    // or close to the previous write so regions overlap
    task automatic pick_instr(output logic dir, output glb_addr_t base,
                              output word_cnt_t cnt, output dram_addr_t dram);
        int start;
        int n;
        dir  = ($unsigned($random(seed)) % 2) != 0;
        cnt  = word_cnt_t'($unsigned($random(seed)) % 8 + 1);
        dram = $random(seed);
        // Nothing to read back yet
        if (last_wr_cnt == 0) begin
            dir = 1'b0;
        end
        if (dir) begin
            start = last_wr_base + int'($unsigned($random(seed)) % last_wr_cnt);
            if (start >= BASE_LIMIT) begin
                start = last_wr_base;
            end
            // Trim to the written run starting at the base
            n = 0;
            while (n < int'(cnt) && model.exists(start + n)) begin
                n++;
            end
            cnt = word_cnt_t'(n);
        end else begin
            if (last_wr_cnt != 0 && ($unsigned($random(seed)) % 2) != 0) begin
                start = (last_wr_base + int'($unsigned($random(seed)) % 4)) % BASE_LIMIT;
            end else begin
                start = int'($unsigned($random(seed)) % BASE_LIMIT);
            end
            last_wr_base = start;
            last_wr_cnt  = int'(cnt);
        end
        base = glb_addr_t'(start);
    endtask

    // ========================================================================
    // One instruction from accept to cfg_rdy high again
    // ========================================================================
    task automatic run_transfer(input logic dir, input glb_addr_t base,
                                input word_cnt_t cnt, input dram_addr_t dram);
        cfg_info_t info;
        port_dat_t exp_cmd;
        port_dat_t exp_dat;
        sram_dat_t word;
        port_dat_t beats [$];
        int        nbeats;
        int        in_idx;
        int        out_idx;
        int        i;
        logic      cmd_done;
        logic      finished;
        logic      in_acc;
        logic      out_acc;

        nbeats = 2 * int'(cnt);
        // Random filler outside the decoded fields
        for (i = 0; i < 8; i++) begin
            info[i*32 +: 32] = $random(seed);
        end
        info[DIR_BIT]          = dir;
        info[CNT_MSB:CNT_LSB]   = cnt;
        info[DRAM_MSB:DRAM_LSB] = dram;
        info[GLB_MSB:GLB_LSB]   = base;
        // Count, DRAM base, direction from the top, zero below
        exp_cmd = {cnt, dram, dir, {(PORT_WIDTH - 49){1'b0}}};
        if (!dir) begin
            for (i = 0; i < nbeats; i++) begin
                beats.push_back(port_dat_t'({$random(seed), $random(seed),
                                             $random(seed), $random(seed)}));
            end
        end

        // Accept in idle, then scramble the bus to prove the fields are held
        cfg_vld     <= 1'b1;
        cfg_info    <= info;
        itf_out_rdy <= ($unsigned($random(seed)) % 3) != 0;
        @(posedge clk);
        check_flag("cfg_rdy", cfg_rdy, 1'b1);
        cfg_vld     <= 1'b0;
        cfg_info    <= ~info;

        cmd_done = 1'b0;
        finished = 1'b0;
        in_idx   = 0;
        out_idx  = 0;
        while (!finished) begin
            itf_out_rdy <= ($unsigned($random(seed)) % 3) != 0;
            @(posedge clk);
            in_acc   = itf_in_vld && itf_in_rdy;
            out_acc  = itf_out_vld && itf_out_rdy;
            finished = cmd_done && cfg_rdy;
            if (out_acc) begin
                if (!cmd_done) begin
                    check_flag("itf_cmd_vld", itf_cmd_vld, 1'b1);
                    check_last(itf_out_last, 1'b1);
                    check_cmd(itf_out_dat, exp_cmd);
                    cmd_done = 1'b1;
                end else if (!dir || out_idx >= nbeats) begin
                    proto_errors++;
                    $display("Error at time %0t: outbound beat with no beat left to send",
                             $time);
                end else begin
                    // Low half first
                    word    = model[int'(base) + out_idx / 2];
                    exp_dat = out_idx[0] ? word[SRAM_WIDTH-1:PORT_WIDTH]
                                         : word[PORT_WIDTH-1:0];
                    check_flag("itf_cmd_vld", itf_cmd_vld, 1'b0);
                    check_beat(itf_out_dat, exp_dat);
                    check_last(itf_out_last, out_idx == nbeats - 1);
                    out_idx++;
                end
            end
            if (in_acc) begin
                in_idx++;
            end
            // Inbound beats held until taken with random gaps between
            if (!itf_in_vld || in_acc) begin
                if (!dir && in_idx < nbeats && ($unsigned($random(seed)) % 4) != 0) begin
                    itf_in_vld  <= 1'b1;
                    itf_in_dat  <= beats[in_idx];
                    itf_in_last <= (in_idx == nbeats - 1);
                end else begin
                    itf_in_vld  <= 1'b0;
                    itf_in_last <= 1'b0;
                end
            end
        end

        if ((dir ? out_idx : in_idx) != nbeats) begin
            proto_errors++;
            $display("Error: %0d-word transfer at base %0d moved %0d inbound, %0d outbound beats",
                     cnt, base, in_idx, out_idx);
        end
        // Earlier beat is the low half
        if (!dir) begin
            for (i = 0; i < int'(cnt); i++) begin
                model[int'(base) + i] = {beats[2*i+1], beats[2*i]};
            end
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin : stimulus
        logic       dir;
        glb_addr_t  base;
        word_cnt_t  cnt;
        dram_addr_t dram;
        int         n;

        seed         = 32'h84462552;
        cmd_errors   = 0;
        beat_errors  = 0;
        last_errors  = 0;
        flag_errors  = 0;
        proto_errors = 0;
        last_wr_base = 0;
        last_wr_cnt  = 0;
        rst_n       <= 1'b0;
        cfg_vld     <= 1'b0;
        cfg_info    <= '0;
        itf_out_rdy <= 1'b0;
        itf_in_dat  <= '0;
        itf_in_vld  <= 1'b0;
        itf_in_last <= 1'b0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Idle after reset
        check_flag("cfg_rdy", cfg_rdy, 1'b1);
        check_flag("itf_cmd_vld", itf_cmd_vld, 1'b0);
        check_flag("itf_out_vld", itf_out_vld, 1'b0);
        check_flag("itf_in_rdy", itf_in_rdy, 1'b0);

        for (n = 0; n < NUM_INSTR; n++) begin
            pick_instr(dir, base, cnt, dram);
            run_transfer(dir, base, cnt, dram);
        end

        $display("Errors: command %0d, data %0d, last %0d, flag %0d, protocol %0d",
                 cmd_errors, beat_errors, last_errors, flag_errors, proto_errors);
        if (cmd_errors + beat_errors + last_errors + flag_errors + proto_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit from the worst-case transfer length
    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not complete within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: source/gic_top.sv
/*
 * Global input controller top
 * Controller core wired to its global buffer
 */
`timescale 1ns/1ps

module gic_top
    import gic_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Instruction from the control unit
    input  logic      cfg_vld,
    output logic      cfg_rdy,
    input  cfg_info_t cfg_info,

    // Outbound off-chip port
    output logic      itf_cmd_vld,
    output port_dat_t itf_out_dat,
    output logic      itf_out_vld,
    output logic      itf_out_last,
    input  logic      itf_out_rdy,

    // Inbound off-chip port
    input  port_dat_t itf_in_dat,
    input  logic      itf_in_vld,
    input  logic      itf_in_last,
    output logic      itf_in_rdy
);

    gic_glb_if glb ();

    gic_core i_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld      (cfg_vld),
        .cfg_rdy      (cfg_rdy),
        .cfg_info     (cfg_info),
        .itf_cmd_vld  (itf_cmd_vld),
        .itf_out_dat  (itf_out_dat),
        .itf_out_vld  (itf_out_vld),
        .itf_out_last (itf_out_last),
        .itf_out_rdy  (itf_out_rdy),
        .itf_in_dat   (itf_in_dat),
        .itf_in_vld   (itf_in_vld),
        .itf_in_last  (itf_in_last),
        .itf_in_rdy   (itf_in_rdy),
        .glb          (glb)
    );

    glb_sram i_glb (
        .clk   (clk),
        .rst_n (rst_n),
        .glb   (glb)
    );

endmodule

// File: source/glb_sram.sv
/*
 * Global buffer model
 * Word array with an always-ready write port and a read port whose
 * registered data slot holds until taken
 */
`timescale 1ns/1ps

module glb_sram
    import gic_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    gic_glb_if.buffer glb
);

    sram_dat_t mem [GLB_DEPTH];
    logic      rd_acc;
    sram_dat_t rd_dat_q;
    logic      rd_vld_q;

    // ========================================================================
    // Write port
    // ========================================================================
    // Never back-pressures
    assign glb.wr_rdy = 1'b1;

    always_ff @(posedge clk) begin
        if (glb.wr_vld) begin
            mem[glb.wr_addr[GLB_IDX_WIDTH-1:0]] <= glb.wr_dat;
        end
    end

    // ========================================================================
    // Read port
    // ========================================================================
    // Slot empty or draining this cycle
    assign glb.rd_addr_rdy = !rd_vld_q || glb.rd_dat_rdy;
    assign rd_acc          = glb.rd_addr_vld && glb.rd_addr_rdy;

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rd_dat_q <= mem[glb.rd_addr[GLB_IDX_WIDTH-1:0]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q <= 1'b0;
        end else if (rd_acc) begin
            rd_vld_q <= 1'b1;
        end else if (glb.rd_dat_rdy) begin
            rd_vld_q <= 1'b0;
        end
    end

    assign glb.rd_dat     = rd_dat_q;
    assign glb.rd_dat_vld = rd_vld_q;

endmodule

// File: source/gic_core.sv
/*
 * Global input controller core
 * Accepts an instruction, sends the command beat, then moves words
 * between the off-chip port and the global buffer in either direction
 */
`timescale 1ns/1ps

module gic_core
    import gic_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cfg_vld,
    output logic           cfg_rdy,
    input  cfg_info_t      cfg_info,
    output logic           itf_cmd_vld,
    output port_dat_t      itf_out_dat,
    output logic           itf_out_vld,
    output logic           itf_out_last,
    input  logic           itf_out_rdy,
    input  port_dat_t      itf_in_dat,
    input  logic           itf_in_vld,
    input  logic           itf_in_last,
    output logic           itf_in_rdy,
    gic_glb_if.controller  glb
);

    gic_state_e state;
    gic_state_e next_state;

    glb_addr_t  glb_base;
    word_cnt_t  word_cnt;
    logic       dir;
    port_dat_t  cmd_word;

    glb_addr_t  addr_cnt;
    word_cnt_t  issued;
    logic       rd_last_q;

    logic       cfg_acc;
    logic       cmd_acc;
    logic       wr_acc;
    logic       rd_addr_acc;
    logic       sipo_in_rdy;
    port_dat_t  piso_dat;
    logic       piso_vld;
    logic       piso_last;

    gic_word_if wr_word ();
    gic_word_if rd_word ();

    // ========================================================================
    // Instruction accept and decode
    // ========================================================================
    assign cfg_rdy = (state == IDLE);
    assign cfg_acc = cfg_vld && cfg_rdy;

    gic_cfg_reg i_cfg_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (cfg_acc),
        .cfg_info (cfg_info),
        .glb_base (glb_base),
        .word_cnt (word_cnt),
        .dir_out  (dir),
        .cmd_word (cmd_word)
    );

    // ========================================================================
    // Transfer FSM
    // ========================================================================
    assign cmd_acc     = (state == CMD) && itf_out_rdy;
    assign wr_acc      = glb.wr_vld && glb.wr_rdy;
    assign rd_addr_acc = glb.rd_addr_vld && glb.rd_addr_rdy;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (cfg_acc) next_state = CMD;
            CMD:     if (cmd_acc) next_state = dir ? OUT2OFF : IN2CHIP;
            // Final packed word written
            IN2CHIP: if (wr_acc && wr_word.last) next_state = IDLE;
            // Last beat taken off-chip
            OUT2OFF: if (itf_out_vld && itf_out_rdy && itf_out_last) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ========================================================================
    // GLB address and issued-word counters
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt <= '0;
            issued   <= '0;
        end else if (cmd_acc) begin
            addr_cnt <= glb_base;
            issued   <= '0;
        end else begin
            if (wr_acc || rd_addr_acc) begin
                addr_cnt <= addr_cnt + 1'b1;
            end
            if (rd_addr_acc) begin
                issued <= issued + 1'b1;
            end
        end
    end

    // Tag follows the address into the read slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_last_q <= 1'b0;
        end else if (rd_addr_acc) begin
            rd_last_q <= (issued == word_cnt - 1'b1);
        end
    end

    // ========================================================================
    // In to chip
    // ========================================================================
    assign itf_in_rdy = (state == IN2CHIP) && sipo_in_rdy;

    gic_sipo i_sipo (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_dat  (itf_in_dat),
        .in_vld  (itf_in_vld && (state == IN2CHIP)),
        .in_last (itf_in_last),
        .in_rdy  (sipo_in_rdy),
        .out     (wr_word)
    );

    assign glb.wr_addr = addr_cnt;
    assign glb.wr_dat  = wr_word.dat;
    assign glb.wr_vld  = (state == IN2CHIP) && wr_word.vld;
    assign wr_word.rdy = (state == IN2CHIP) && glb.wr_rdy;

    // ========================================================================
    // Out to off-chip
    // ========================================================================
    assign glb.rd_addr     = addr_cnt;
    assign glb.rd_addr_vld = (state == OUT2OFF) && (issued < word_cnt);
    assign glb.rd_dat_rdy  = (state == OUT2OFF) && rd_word.rdy;

    assign rd_word.dat  = glb.rd_dat;
    assign rd_word.vld  = (state == OUT2OFF) && glb.rd_dat_vld;
    assign rd_word.last = rd_last_q;

    gic_piso i_piso (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (rd_word),
        .out_dat  (piso_dat),
        .out_vld  (piso_vld),
        .out_last (piso_last),
        .out_rdy  (itf_out_rdy && (state == OUT2OFF))
    );

    // Command beat first, then PISO beats
    assign itf_cmd_vld  = (state == CMD);
    assign itf_out_dat  = (state == CMD)     ? cmd_word :
                          (state == OUT2OFF) ? piso_dat : '0;
    assign itf_out_vld  = (state == CMD) || ((state == OUT2OFF) && piso_vld);
    assign itf_out_last = (state == CMD) || ((state == OUT2OFF) && piso_last);

endmodule

// File: source/gic_piso.sv
/*
 * Word-to-beat splitter
 * Sends a buffer word as two off-chip beats, low half first, with
 * last on the high half of a word tagged last
 */
`timescale 1ns/1ps

module gic_piso
    import gic_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    gic_word_if.sink         in,
    output port_dat_t        out_dat,
    output logic             out_vld,
    output logic             out_last,
    input  logic             out_rdy
);

    sram_dat_t word_q;
    logic      word_last;
    logic      full;
    logic      hi_sel;
    logic      word_acc;
    logic      beat_acc;

    assign beat_acc = full && out_rdy;

    // Empty, or final beat leaving on this edge
    assign in.rdy   = !full || (hi_sel && out_rdy);
    assign word_acc = in.vld && in.rdy;

    // Payload
    always_ff @(posedge clk) begin
        if (word_acc) begin
            word_q    <= in.dat;
            word_last <= in.last;
        end
    end

    // ========================================================================
    // Occupancy and half select
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full   <= 1'b0;
            hi_sel <= 1'b0;
        end else if (word_acc) begin
            // Fresh word starts on its low half
            full   <= 1'b1;
            hi_sel <= 1'b0;
        end else if (beat_acc) begin
            if (hi_sel) begin
                full   <= 1'b0;
                hi_sel <= 1'b0;
            end else begin
                hi_sel <= 1'b1;
            end
        end
    end

    // Beat select
    assign out_dat  = hi_sel ? word_q[SRAM_WIDTH-1:PORT_WIDTH] : word_q[PORT_WIDTH-1:0];
    assign out_vld  = full;
    assign out_last = full && hi_sel && word_last;

endmodule

// File: source/gic_sipo.sv
/*
 * Beat-to-word packer
 * Gathers two off-chip beats into one buffer word, earlier beat in
 * the low half, and carries the last flag of the second beat
 */
`timescale 1ns/1ps

module gic_sipo
    import gic_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  port_dat_t        in_dat,
    input  logic             in_vld,
    input  logic             in_last,
    output logic             in_rdy,
    gic_word_if.source       out
);

    port_dat_t lo_half;
    logic      phase;
    sram_dat_t word_q;
    logic      word_vld;
    logic      word_last;
    logic      beat_acc;

    // Hold off new beats while a finished word waits downstream
    assign in_rdy   = !word_vld || out.rdy;
    assign beat_acc = in_vld && in_rdy;

    // Low half storage
    always_ff @(posedge clk) begin
        if (beat_acc && !phase) begin
            lo_half <= in_dat;
        end
    end

    // Word register loads on the second beat
    always_ff @(posedge clk) begin
        if (beat_acc && phase) begin
            word_q    <= {in_dat, lo_half};
            word_last <= in_last;
        end
    end

    // Beat phase and word valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= 1'b0;
            word_vld <= 1'b0;
        end else begin
            if (beat_acc) begin
                phase <= !phase;
            end
            if (beat_acc && phase) begin
                word_vld <= 1'b1;
            end else if (out.rdy) begin
                word_vld <= 1'b0;
            end
        end
    end

    assign out.dat  = word_q;
    assign out.vld  = word_vld;
    assign out.last = word_last;

endmodule

// File: source/gic_cfg_reg.sv
/*
 * Instruction register
 * Latches direction, count and base addresses of an accepted
 * instruction and builds the off-chip command word
 */
`timescale 1ns/1ps

module gic_cfg_reg
    import gic_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  cfg_info_t cfg_info,
    output glb_addr_t glb_base,
    output word_cnt_t word_cnt,
    output logic      dir_out,
    output port_dat_t cmd_word
);

    // Only needed for the command word
    dram_addr_t dram_base;

    // Field capture on the accept edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            glb_base  <= '0;
            word_cnt  <= '0;
            dram_base <= '0;
            dir_out   <= 1'b0;
        end else if (load) begin
            glb_base  <= cfg_info[GLB_MSB:GLB_LSB];
            word_cnt  <= cfg_info[CNT_MSB:CNT_LSB];
            dram_base <= cfg_info[DRAM_MSB:DRAM_LSB];
            dir_out   <= cfg_info[DIR_BIT];
        end
    end

    // Count, DRAM base, direction from the top bit down
    // 0 means in to chip, 1 means out to off-chip
    assign cmd_word = {word_cnt, dram_base, dir_out, {CMD_PAD_WIDTH{1'b0}}};

endmodule

// File: source/gic_word_if.sv
/*
 * Buffer-width word stream
 * Data with valid, last and ready between the width converters and
 * the buffer ports
 */
`timescale 1ns/1ps

interface gic_word_if
    import gic_pkg::*;
();

    sram_dat_t dat;
    logic      vld;
    logic      last;
    logic      rdy;

    modport source (
        output dat, vld, last,
        input  rdy
    );

    modport sink (
        input  dat, vld, last,
        output rdy
    );

endinterface

// File: source/gic_glb_if.sv
/*
 * Global buffer port bundle
 * Write port plus split address/data read port, each with its own
 * valid/ready handshake
 */
`timescale 1ns/1ps

interface gic_glb_if
    import gic_pkg::*;
();

    // Write side
    glb_addr_t wr_addr;
    sram_dat_t wr_dat;
    logic      wr_vld;
    logic      wr_rdy;

    // Read address and read data
    glb_addr_t rd_addr;
    logic      rd_addr_vld;
    logic      rd_addr_rdy;
    sram_dat_t rd_dat;
    logic      rd_dat_vld;
    logic      rd_dat_rdy;

    // Controller side drives addresses and write data
    modport controller (
        output wr_addr, wr_dat, wr_vld, rd_addr, rd_addr_vld, rd_dat_rdy,
        input  wr_rdy, rd_addr_rdy, rd_dat, rd_dat_vld
    );

    modport buffer (
        input  wr_addr, wr_dat, wr_vld, rd_addr, rd_addr_vld, rd_dat_rdy,
        output wr_rdy, rd_addr_rdy, rd_dat, rd_dat_vld
    );

endinterface

// File: source/gic_pkg.sv
/*
 * Global input controller shared definitions
 * Port and buffer widths, instruction field positions, data types
 * and the transfer state encoding
 */
package gic_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int PORT_WIDTH      = 128;
    localparam int SRAM_WIDTH      = 256;
    localparam int GLB_ADDR_WIDTH  = 16;
    localparam int DRAM_ADDR_WIDTH = 32;
    localparam int GLB_DEPTH       = 256;
    // Word index bits actually used by the modeled buffer
    localparam int GLB_IDX_WIDTH   = $clog2(GLB_DEPTH);

    // Instruction word layout
    localparam int DIR_BIT  = 9;
    localparam int CNT_LSB  = 10;
    localparam int CNT_MSB  = 25;
    localparam int DRAM_LSB = 26;
    localparam int DRAM_MSB = 57;
    localparam int GLB_LSB  = 58;
    localparam int GLB_MSB  = 73;

    // Zero fill below count, DRAM base and direction in the command word
    localparam int CMD_PAD_WIDTH = PORT_WIDTH - GLB_ADDR_WIDTH - DRAM_ADDR_WIDTH - 1;

    // ========================================================================
    // Types
    // ========================================================================
    typedef logic [PORT_WIDTH-1:0]      port_dat_t;
    typedef logic [SRAM_WIDTH-1:0]      sram_dat_t;
    typedef logic [GLB_ADDR_WIDTH-1:0]  glb_addr_t;
    typedef logic [DRAM_ADDR_WIDTH-1:0] dram_addr_t;
    typedef logic [15:0]                word_cnt_t;
    typedef logic [2*PORT_WIDTH-1:0]    cfg_info_t;

    // Transfer FSM
    typedef enum logic [1:0] {
        IDLE,
        CMD,
        IN2CHIP,
        OUT2OFF
    } gic_state_e;

endpackage
